/* sources.f */
verilog/fcore_pkg.sv
verilog/program_memory.sv
verilog/control_unit.sv
verilog/arith_unit.sv
verilog/compare_unit.sv
verilog/register_file.sv
verilog/fcore_top.sv
sim/fcore_tb.sv

/* Makefile */
TOP = fcore_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

/* sim/fcore_tb.sv */
/*
 * Testbench for the multichannel core. Builds program images, loads them
 * through the host port, runs them on a random number of channels and
 * checks the outputs and register contents against a per-channel model.
 */
`timescale 1ns/1ns
`default_nettype none

module fcore_tb
    import fcore_pkg::*;
();

    logic                   clock;
    logic                   rst;
    logic                   run;
    logic [pc_width-1:0]    program_size;
    logic [chan_width:0]    n_channels;
    logic                   mem_we;
    logic [pc_width-1:0]    mem_addr;
    logic [instr_width-1:0] mem_wdata;
    host_access_t           host;
    logic [instr_width-1:0] host_rdata;
    logic                   io_map_valid;
    logic [instr_width-1:0] io_map_data;
    logic                   busy;
    logic                   done;
    logic                   fault;

    // Image under construction and the mapping words it should emit
    logic [instr_width-1:0] image [$];
    logic [instr_width-1:0] exp_map [64];
    int                     exp_map_count;
    int                     map_idx;
    logic [instr_width-1:0] map_expect;

    // Register contents as the ISA rules predict them
    logic [instr_width-1:0] model [max_channels][16];
    int                     n_active;

    logic                   rd_pending;
    logic [instr_width-1:0] rd_expect;
    logic [instr_width-1:0] rd_expect_q;
    logic [chan_width-1:0]  rd_chan_q;
    logic [3:0]             rd_addr_q;

    fcore_top fcore_top_inst (
        .clock        (clock),
        .rst          (rst),
        .run          (run),
        .program_size (program_size),
        .n_channels   (n_channels),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .host         (host),
        .host_rdata   (host_rdata),
        .io_map_valid (io_map_valid),
        .io_map_data  (io_map_data),
        .busy         (busy),
        .done         (done),
        .fault        (fault)
    );

    always #5 clock = ~clock;

    task automatic flag_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "value check failed");
    endtask

    task automatic abort_on_timeout(input string what, input int limit);
        $display("Timed out after %0d cycles waiting for %s", limit, what);
        $display("STATUS: FAIL");
        $fatal(1, "wait timed out");
    endtask

    // Tracks host reads in flight and the position in the mapping section
    always @(posedge clock) begin
        if (rst) begin
            rd_pending <= 1'b0;
            map_idx <= 0;
        end else begin
            rd_pending <= host.valid && !host.write && !busy;
            rd_expect_q <= rd_expect;
            rd_chan_q <= host.channel;
            rd_addr_q <= host.addr;
            if (run && !busy) begin
                map_idx <= 0;
            end else if (io_map_valid) begin
                map_idx <= map_idx + 1;
            end
        end
    end

    always_comb begin
        map_expect = exp_map[map_idx[5:0]];
    end

    map_order: assert property (
        @(posedge clock) disable iff (rst)
        io_map_valid |-> (map_idx < exp_map_count && io_map_data == map_expect)
    ) else flag_mismatch($sformatf("io map word %0d is %h, expected %h",
        $sampled(map_idx), $sampled(io_map_data), $sampled(map_expect)));

    host_read: assert property (
        @(posedge clock) disable iff (rst)
        rd_pending |-> host_rdata == rd_expect_q
    ) else flag_mismatch($sformatf("channel %0d reg %0d reads %h, expected %h",
        $sampled(rd_chan_q), $sampled(rd_addr_q), $sampled(host_rdata),
        $sampled(rd_expect_q)));

    done_single: assert property (
        @(posedge clock) disable iff (rst)
        done |=> !done
    ) else flag_mismatch("done stays high for more than one cycle");

    done_idle: assert property (
        @(posedge clock) disable iff (rst)
        done |-> (!busy && !fault)
    ) else flag_mismatch("busy or fault still high with done");

    // A fault holds until the next run strobe clears it
    fault_held: assert property (
        @(posedge clock) disable iff (rst)
        (fault && !run) |=> fault
    ) else flag_mismatch("fault dropped without a new run");

    function automatic logic [instr_width-1:0] encode(input opcode_t op, input int rd,
                                                      input int rs1, input int rs2);
        return {15'd0, reg_addr_width'(rs2), reg_addr_width'(rs1), reg_addr_width'(rd), op};
    endfunction

    function automatic logic [instr_width-1:0] section_word();
        logic [instr_width-1:0] w;
        w = $urandom();
        while (w == section_end) begin
            w = $urandom();
        end
        return w;
    endfunction

    // Applies one instruction to every active channel of the model
    function automatic void apply_model(input logic [instr_width-1:0] word,
                                        input logic [instr_width-1:0] cword);
        opcode_t                op;
        int                     rd;
        logic [instr_width-1:0] a;
        logic [instr_width-1:0] b;
        op = opcode_t'(word[4:0]);
        rd = int'(word[8:5]);
        for (int ch = 0; ch < n_active; ch++) begin
            a = model[ch][word[12:9]];
            b = model[ch][word[16:13]];
            case (op)
                add: model[ch][rd] = a + b;
                sub: model[ch][rd] = a - b;
                and_op: model[ch][rd] = a & b;
                or_op: model[ch][rd] = a | b;
                bgt: model[ch][rd] = ($signed(a) > $signed(b)) ? 32'd1 : 32'd0;
                ble: model[ch][rd] = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
                beq: model[ch][rd] = (a == b) ? 32'd1 : 32'd0;
                ldc: model[ch][rd] = cword;
                default: ;
            endcase
        end
    endfunction

    function automatic void begin_image(input int n_meta, input int n_map);
        image.delete();
        repeat (n_meta) begin
            image.push_back(section_word());
        end
        image.push_back(section_end);
        for (int i = 0; i < n_map; i++) begin
            exp_map[i] = section_word();
            image.push_back(exp_map[i]);
        end
        exp_map_count = n_map;
        image.push_back(section_end);
    endfunction

    function automatic void emit(input logic [instr_width-1:0] word);
        image.push_back(word);
        apply_model(word, '0);
    endfunction

    function automatic void emit_ldc(input int rd, input logic [instr_width-1:0] k);
        image.push_back(encode(ldc, rd, 0, 0));
        image.push_back(k);
        apply_model(encode(ldc, rd, 0, 0), k);
    endfunction

    task automatic load_image();
        foreach (image[i]) begin
            @(posedge clock);
            mem_we <= 1'b1;
            mem_addr <= pc_width'(i);
            mem_wdata <= image[i];
        end
        @(posedge clock);
        mem_we <= 1'b0;
    endtask

    task automatic write_reg(input int ch, input int r, input logic [instr_width-1:0] data);
        @(posedge clock);
        host.valid <= 1'b1;
        host.write <= 1'b1;
        host.channel <= chan_width'(ch);
        host.addr <= reg_addr_width'(r);
        host.wdata <= data;
        model[ch][r] = data;
        @(posedge clock);
        host.valid <= 1'b0;
    endtask

    task automatic read_reg(input int ch, input int r);
        @(posedge clock);
        host.valid <= 1'b1;
        host.write <= 1'b0;
        host.channel <= chan_width'(ch);
        host.addr <= reg_addr_width'(r);
        rd_expect <= model[ch][r];
        @(posedge clock);
        host.valid <= 1'b0;
    endtask

    task automatic preset_regs();
        for (int ch = 0; ch < max_channels; ch++) begin
            for (int r = 0; r < 16; r++) begin
                write_reg(ch, r, $urandom());
            end
        end
    endtask

    task automatic check_all_regs();
        for (int ch = 0; ch < max_channels; ch++) begin
            for (int r = 0; r < 16; r++) begin
                read_reg(ch, r);
            end
        end
        @(posedge clock);
    endtask

    // Sel 0 waits for done, 1 for fault, anything else for a mapping strobe
    task automatic await_signal(input int sel, input int limit, input string what);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clock);
            case (sel)
                0: seen = done;
                1: seen = fault;
                default: seen = io_map_valid;
            endcase
            cycles++;
            if (!seen && cycles >= limit) begin
                abort_on_timeout(what, limit);
            end
        end
    endtask

    task automatic start_run();
        load_image();
        @(posedge clock);
        run <= 1'b1;
        program_size <= pc_width'(image.size());
        n_channels <= n_active[chan_width:0];
        @(posedge clock);
        run <= 1'b0;
        await_signal(2, 64, "the first io map strobe");
    endtask

    task automatic run_to_done();
        start_run();
        await_signal(0, 4000, "done");
        assert (map_idx == exp_map_count)
        else flag_mismatch($sformatf("%0d io map strobes, expected %0d",
            map_idx, exp_map_count));
        check_all_regs();
    endtask

    initial begin
        void'($urandom(32'h983e4ef8));
        clock = 1'b0;
        rst = 1'b1;
        run = 1'b0;
        program_size = '0;
        n_channels = 1;
        mem_we = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        host = '0;
        rd_expect = '0;
        exp_map_count = 0;
        foreach (model[ch, r]) begin
            model[ch][r] = '0;
        end
        repeat (5) @(posedge clock);
        rst <= 1'b0;

        // Arithmetic on preset registers, which also exercises the mapping output
        n_active = $urandom_range(max_channels, 1);
        preset_regs();
        begin_image($urandom_range(4, 0), $urandom_range(6, 1));
        repeat (12) begin
            emit(encode(opcode_t'(opcode_width'($urandom_range(4, 1))),
                $urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(15, 0)));
        end
        image.push_back(encode(stop, 0, 0, 0));
        run_to_done();

        // Comparisons, with r5 and r6 equal in every channel
        n_active = $urandom_range(max_channels, 1);
        preset_regs();
        for (int ch = 0; ch < max_channels; ch++) begin
            write_reg(ch, 6, model[ch][5]);
        end
        begin_image($urandom_range(4, 0), $urandom_range(6, 1));
        emit(encode(bgt, 7, 1, 2));
        emit(encode(ble, 8, 3, 4));
        emit(encode(beq, 9, 5, 6));
        emit(encode(bgt, 10, 5, 6));
        emit(encode(ble, 11, 5, 6));
        emit(encode(beq, 12, 1, 2));
        repeat (6) begin
            emit(encode(opcode_t'(opcode_width'($urandom_range(7, 5))),
                $urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(15, 0)));
        end
        image.push_back(encode(stop, 0, 0, 0));
        run_to_done();

        // Constant loads, one of them equal to the terminator value
        n_active = $urandom_range(max_channels, 1);
        begin_image($urandom_range(4, 0), $urandom_range(6, 1));
        emit_ldc(1, $urandom());
        emit(encode(add, 2, 1, 1));
        emit_ldc(3, section_end);
        emit(encode(or_op, 4, 3, 2));
        image.push_back(encode(stop, 0, 0, 0));
        run_to_done();

        // No STOP, so the run must end in a fault
        n_active = $urandom_range(max_channels, 1);
        begin_image($urandom_range(4, 0), $urandom_range(6, 1));
        repeat (4) begin
            emit(encode(sub, $urandom_range(15, 0), $urandom_range(15, 0),
                $urandom_range(15, 0)));
        end
        start_run();
        await_signal(1, 4000, "fault");
        repeat (10) @(posedge clock);
        assert (!busy) else flag_mismatch("busy still high after fault");
        write_reg(0, 0, $urandom());
        write_reg(max_channels - 1, 15, $urandom());
        check_all_regs();

        // A following run clears the fault
        n_active = $urandom_range(max_channels, 1);
        begin_image($urandom_range(4, 0), $urandom_range(6, 1));
        emit(encode(and_op, 5, 0, 15));
        image.push_back(encode(stop, 0, 0, 0));
        run_to_done();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fcore_top.sv */
/*
 * Top level of the multichannel core. Joins program memory, sequencer,
 * both execution units and the register banks; host accesses to memory
 * and registers pass only while the core is not busy.
 */
`timescale 1ns/1ns
`default_nettype none

module fcore_top
    import fcore_pkg::*;
(
    input  wire                    clock,
    input  wire                    rst,
    input  wire                    run,
    input  wire [pc_width-1:0]     program_size,
    input  wire [chan_width:0]     n_channels,
    input  wire                    mem_we,
    input  wire [pc_width-1:0]     mem_addr,
    input  wire [instr_width-1:0]  mem_wdata,
    input  wire host_access_t      host,
    output logic [instr_width-1:0] host_rdata,
    output logic                   io_map_valid,
    output logic [instr_width-1:0] io_map_data,
    output logic                   busy,
    output logic                   done,
    output logic                   fault
);

    logic [pc_width-1:0]    pc;
    logic [instr_width-1:0] word0;
    logic [instr_width-1:0] word1;
    issue_t                 issue;
    opcode_t                exec_op;
    logic [instr_width-1:0] op_a;
    logic [instr_width-1:0] op_b;
    logic [instr_width-1:0] arith_result;
    logic                   arith_writes;
    logic [instr_width-1:0] cmp_result;
    logic                   cmp_writes;

    assign exec_op = get_opcode(issue.instr);

    program_memory program_memory_inst (
        .clock     (clock),
        .mem_we    (mem_we && !busy),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .pc        (pc),
        .word0     (word0),
        .word1     (word1)
    );

    control_unit control_unit_inst (
        .clock        (clock),
        .rst          (rst),
        .run          (run),
        .program_size (program_size),
        .n_channels   (n_channels),
        .word0        (word0),
        .word1        (word1),
        .pc           (pc),
        .io_map_valid (io_map_valid),
        .io_map_data  (io_map_data),
        .issue        (issue),
        .busy         (busy),
        .done         (done),
        .fault        (fault)
    );

    arith_unit arith_unit_inst (
        .opcode (exec_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (arith_result),
        .writes (arith_writes)
    );

    compare_unit compare_unit_inst (
        .opcode (exec_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (cmp_result),
        .writes (cmp_writes)
    );

    register_file register_file_inst (
        .clock        (clock),
        .rst          (rst),
        .issue        (issue),
        .op_a         (op_a),
        .op_b         (op_b),
        .arith_result (arith_result),
        .arith_writes (arith_writes),
        .cmp_result   (cmp_result),
        .cmp_writes   (cmp_writes),
        .host         (host),
        .host_enable  (!busy),
        .host_rdata   (host_rdata)
    );

endmodule

`default_nettype wire

/* verilog/register_file.sv */
/*
 * Per-channel register banks. Serves both operands of the issued beat,
 * picks the value to write back by opcode and gives the host a port for
 * presetting and reading registers while the core is idle.
 */
`timescale 1ns/1ns
`default_nettype none

module register_file
    import fcore_pkg::*;
(
    input  wire                    clock,
    input  wire                    rst,
    input  wire issue_t            issue,
    output logic [instr_width-1:0] op_a,
    output logic [instr_width-1:0] op_b,
    input  wire [instr_width-1:0]  arith_result,
    input  wire                    arith_writes,
    input  wire [instr_width-1:0]  cmp_result,
    input  wire                    cmp_writes,
    input  wire host_access_t      host,
    input  wire                    host_enable,
    output logic [instr_width-1:0] host_rdata
);

    localparam int n_regs = 2 ** reg_addr_width;

    logic [instr_width-1:0] regs [max_channels][n_regs];
    opcode_t                issue_op;
    logic                   wb_en;
    logic [instr_width-1:0] wb_data;

    assign issue_op = get_opcode(issue.instr);

    assign op_a = regs[issue.channel][get_rs1(issue.instr)];
    assign op_b = regs[issue.channel][get_rs2(issue.instr)];

    // Constant loads bypass both execution units
    always_comb begin
        wb_en = issue.valid && (issue_op == ldc || arith_writes || cmp_writes);
        if (issue_op == ldc) begin
            wb_data = issue.constant;
        end else if (arith_writes) begin
            wb_data = arith_result;
        end else begin
            wb_data = cmp_result;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int ch = 0; ch < max_channels; ch++) begin
                for (int r = 0; r < n_regs; r++) begin
                    regs[ch][r] <= '0;
                end
            end
        end else begin
            if (wb_en) begin
                regs[issue.channel][get_rd(issue.instr)] <= wb_data;
            end
            if (host.valid && host_enable && host.write) begin
                regs[host.channel][host.addr] <= host.wdata;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (host.valid && host_enable && !host.write) begin
            host_rdata <= regs[host.channel][host.addr];
        end
    end

    // Both units decode the same opcode, so at most one may claim the result
    single_writer: assert property (
        @(posedge clock) disable iff (rst)
        issue.valid |-> !(arith_writes && cmp_writes)
    );

endmodule

`default_nettype wire

/* verilog/compare_unit.sv */
/*
 * Comparison unit. Signed greater-than and less-or-equal plus equality,
 * each giving a result of exactly 1 or 0.
 */
`timescale 1ns/1ns
`default_nettype none

module compare_unit
    import fcore_pkg::*;
(
    input  wire opcode_t           opcode,
    input  wire [instr_width-1:0]  op_a,
    input  wire [instr_width-1:0]  op_b,
    output logic [instr_width-1:0] result,
    output logic                   writes
);

    logic flag;

    always_comb begin
        flag = 1'b0;
        writes = 1'b0;
        case (opcode)
            bgt: begin
                flag = $signed(op_a) > $signed(op_b);
                writes = 1'b1;
            end
            ble: begin
                flag = $signed(op_a) <= $signed(op_b);
                writes = 1'b1;
            end
            beq: begin
                flag = (op_a == op_b);
                writes = 1'b1;
            end
            default: begin
                flag = 1'b0;
                writes = 1'b0;
            end
        endcase
    end

    assign result = {{(instr_width-1){1'b0}}, flag};

endmodule

`default_nettype wire

/* verilog/arith_unit.sv */
/*
 * Arithmetic unit. Wrapping 32-bit add and subtract plus bitwise and/or,
 * with a flag telling the register file that the result is to be stored.
 */
`timescale 1ns/1ns
`default_nettype none

module arith_unit
    import fcore_pkg::*;
(
    input  wire opcode_t           opcode,
    input  wire [instr_width-1:0]  op_a,
    input  wire [instr_width-1:0]  op_b,
    output logic [instr_width-1:0] result,
    output logic                   writes
);

    always_comb begin
        result = '0;
        writes = 1'b0;
        case (opcode)
            add: begin
                result = op_a + op_b;
                writes = 1'b1;
            end
            sub: begin
                result = op_a - op_b;
                writes = 1'b1;
            end
            and_op: begin
                result = op_a & op_b;
                writes = 1'b1;
            end
            or_op: begin
                result = op_a | op_b;
                writes = 1'b1;
            end
            default: begin
                // Other opcodes leave the result unused
                result = '0;
                writes = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
/*
 * Control unit. Steps over the metadata and I/O mapping sections of the
 * image, then issues every code instruction once per channel before the
 * program counter moves on. Ends a run on STOP or on a fault.
 */
`timescale 1ns/1ns
`default_nettype none

module control_unit
    import fcore_pkg::*;
(
    input  wire                    clock,
    input  wire                    rst,
    input  wire                    run,
    input  wire [pc_width-1:0]     program_size,
    input  wire [chan_width:0]     n_channels,
    input  wire [instr_width-1:0]  word0,
    input  wire [instr_width-1:0]  word1,
    output logic [pc_width-1:0]    pc,
    output logic                   io_map_valid,
    output logic [instr_width-1:0] io_map_data,
    output issue_t                 issue,
    output logic                   busy,
    output logic                   done,
    output logic                   fault
);

    typedef enum logic [2:0] {
        st_idle,
        st_metadata,
        st_io_mapping,
        st_run,
        st_fault
    } state_t;

    state_t                state;
    logic [chan_width-1:0] channel;
    logic [pc_width-1:0]   size_q;
    logic [chan_width:0]   chans_q;
    opcode_t               word_op;
    logic                  last_channel;
    logic [pc_width-1:0]   pc_step;

    assign word_op = get_opcode(word0);
    assign last_channel = ({1'b0, channel} == chans_q - 1'b1);

    // A constant load consumes the following word as well
    assign pc_step = (word_op == ldc) ? pc_width'(2) : pc_width'(1);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= st_idle;
            pc <= '0;
            channel <= '0;
            size_q <= '0;
            chans_q <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            fault <= 1'b0;
            io_map_valid <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            done <= 1'b0;
            io_map_valid <= 1'b0;
            issue.valid <= 1'b0;

            case (state)
                st_idle, st_fault: begin
                    // A new run also clears a pending fault
                    if (run) begin
                        state <= st_metadata;
                        pc <= '0;
                        channel <= '0;
                        size_q <= program_size;
                        chans_q <= n_channels;
                        busy <= 1'b1;
                        fault <= 1'b0;
                    end
                end

                st_metadata: begin
                    if (word0 == section_end) begin
                        state <= st_io_mapping;
                    end
                    pc <= pc + 1'b1;
                end

                st_io_mapping: begin
                    if (word0 == section_end) begin
                        state <= st_run;
                    end else begin
                        io_map_valid <= 1'b1;
                        io_map_data <= word0;
                    end
                    pc <= pc + 1'b1;
                end

                st_run: begin
                    if (pc >= size_q) begin
                        state <= st_fault;
                        fault <= 1'b1;
                        busy <= 1'b0;
                    end else if (word_op == stop) begin
                        state <= st_idle;
                        done <= 1'b1;
                        busy <= 1'b0;
                    end else begin
                        issue.valid <= 1'b1;
                        issue.instr <= word0;
                        issue.constant <= word1;
                        issue.channel <= channel;
                        if (last_channel) begin
                            channel <= '0;
                            pc <= pc + pc_step;
                        end else begin
                            channel <= channel + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Zero channels would leave the channel counter without an end
    run_channels_nonzero: assert property (
        @(posedge clock) disable iff (rst)
        run |-> (n_channels != '0)
    );

endmodule

`default_nettype wire

/* verilog/program_memory.sv */
/*
 * Program memory. The host fills it one word per cycle, and the core reads
 * the word at pc together with the one after it, both without delay.
 */
`timescale 1ns/1ns
`default_nettype none

module program_memory
    import fcore_pkg::*;
(
    input  wire                    clock,
    input  wire                    mem_we,
    input  wire [pc_width-1:0]     mem_addr,
    input  wire [instr_width-1:0]  mem_wdata,
    input  wire [pc_width-1:0]     pc,
    output logic [instr_width-1:0] word0,
    output logic [instr_width-1:0] word1
);

    localparam int depth = 2 ** pc_width;

    logic [instr_width-1:0] mem [depth];
    logic [pc_width-1:0]    next_addr;

    // The second address wraps to zero past the last word
    assign next_addr = pc + 1'b1;

    always_ff @(posedge clock) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    assign word0 = mem[pc];
    assign word1 = mem[next_addr];

endmodule

`default_nettype wire

/* verilog/fcore_pkg.sv */
/*
 * Shared definitions of the multichannel soft core: field layout of the
 * instruction word, opcode set, size limits and the structs that carry
 * issued beats and host register accesses between the blocks.
 */
`default_nettype none

package fcore_pkg;

    localparam int pc_width = 10;
    localparam int instr_width = 32;
    localparam int opcode_width = 5;
    localparam int reg_addr_width = 4;
    localparam int max_channels = 8;
    localparam int chan_width = 3;
    localparam logic [instr_width-1:0] section_end = 32'hC;

    // Bit positions of the instruction fields
    localparam int opcode_lsb = 0;
    localparam int rd_lsb = 5;
    localparam int rs1_lsb = 9;
    localparam int rs2_lsb = 13;

    typedef enum logic [opcode_width-1:0] {
        nop    = 5'd0,
        add    = 5'd1,
        sub    = 5'd2,
        and_op = 5'd3,
        or_op  = 5'd4,
        bgt    = 5'd5,
        ble    = 5'd6,
        beq    = 5'd7,
        ldc    = 5'd8,
        stop   = 5'd9
    } opcode_t;

    typedef struct packed {
        logic                   valid;
        logic [instr_width-1:0] instr;
        logic [instr_width-1:0] constant;
        logic [chan_width-1:0]  channel;
    } issue_t;

    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [chan_width-1:0]     channel;
        logic [reg_addr_width-1:0] addr;
        logic [instr_width-1:0]    wdata;
    } host_access_t;

    function automatic opcode_t get_opcode(input logic [instr_width-1:0] word);
        return opcode_t'(word[opcode_lsb +: opcode_width]);
    endfunction

    function automatic logic [reg_addr_width-1:0] get_rd(input logic [instr_width-1:0] word);
        return word[rd_lsb +: reg_addr_width];
    endfunction

    function automatic logic [reg_addr_width-1:0] get_rs1(input logic [instr_width-1:0] word);
        return word[rs1_lsb +: reg_addr_width];
    endfunction

    function automatic logic [reg_addr_width-1:0] get_rs2(input logic [instr_width-1:0] word);
        return word[rs2_lsb +: reg_addr_width];
    endfunction

    // True for the opcodes served by the comparison unit
    function automatic logic is_compare(input opcode_t op);
        return (op == bgt) || (op == ble) || (op == beq);
    endfunction

endpackage

`default_nettype wire
